/* common/rename_pkg.sv */
package rename_pkg;

    localparam int xlen = 32;
    localparam int num_regs = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] rob_idx_t;  // Sizes an 8-entry ROB.

    // Newest pending writer of a register.
    typedef struct packed {
        logic     pending;
        rob_idx_t idx;
    } rob_tag_t;

    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,
        op_branch = 2'd3
    } opcode_e;

    typedef struct packed {
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    pc;
        word_t    imm;
    } dec_instr_t;

    typedef struct packed {
        logic     ready;
        word_t    data;  // Valid only when ready.
        rob_tag_t tag;
    } operand_t;

    typedef struct packed {
        dec_instr_t instr;
        operand_t   src1;
        operand_t   src2;
        rob_idx_t   rob_idx;
    } disp_instr_t;

    typedef struct packed {
        rob_idx_t idx;
        word_t    data;
    } wb_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     writes_rd;
    } commit_t;

    // Only ALU ops and loads produce a register result.
    function automatic logic op_writes_rd(opcode_e op);
        return (op == op_alu) || (op == op_load);
    endfunction

    // Renaming also skips x0.
    function automatic logic renames_rd(dec_instr_t instr);
        return op_writes_rd(instr.op) && (instr.rd != '0);
    endfunction

endpackage

/* regfile/rename_regfile.sv */
`timescale 1ns/100ps

module rename_regfile
    import rename_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,

    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    output rob_tag_t rs1_tag,
    output rob_tag_t rs2_tag,

    input  logic     rename_en,
    input  reg_idx_t rename_rd,
    input  rob_idx_t rename_idx,

    input  logic     commit_valid,
    input  commit_t  commit,
    input  rob_idx_t commit_idx
);

    if (ROB_DEPTH != 2 ** $bits(rob_idx_t)) begin : g_depth_check
        $error("ROB_DEPTH must be 2 ** $bits(rob_idx_t)");
    end

    word_t    values_q [num_regs];
    rob_tag_t tags_q   [num_regs];

    logic     commit_wr;
    logic     commit_clr;

    // x0 is never written or tagged, so the arrays already read zero there.
    assign rs1_data = values_q[rs1_idx];
    assign rs2_data = values_q[rs2_idx];
    assign rs1_tag  = tags_q[rs1_idx];
    assign rs2_tag  = tags_q[rs2_idx];

    assign commit_wr  = commit_valid && commit.writes_rd && (commit.rd != '0);
    // A younger writer may already own the register.
    assign commit_clr = commit_wr && tags_q[commit.rd].pending
                        && (tags_q[commit.rd].idx == commit_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                values_q[i] <= '0;
                tags_q[i]   <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < num_regs; i++) begin
                tags_q[i] <= '0;  // Values stay.
            end
        end else begin
            if (commit_wr) begin
                values_q[commit.rd] <= commit.data;
            end
            if (commit_clr) begin
                tags_q[commit.rd] <= '0;
            end
            // Later assignment wins over a same-cycle commit clear.
            if (rename_en && (rename_rd != '0)) begin
                tags_q[rename_rd] <= '{pending: 1'b1, idx: rename_idx};
            end
        end
    end

    // The committing entry or a younger writer still holds the tag.
    assert property (@(posedge clk) disable iff (rst)
        commit_wr |-> tags_q[commit.rd].pending)
        else $error("commit to x%0d without a pending tag", commit.rd);

endmodule

/* rob/reorder_buffer.sv */
`timescale 1ns/100ps

module reorder_buffer
    import rename_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,

    input  logic       alloc,
    input  dec_instr_t alloc_instr,
    output rob_idx_t   alloc_idx,
    output logic       full,

    input  logic       wb_valid,
    input  wb_t        wb,

    input  rob_idx_t   byp1_idx,
    input  rob_idx_t   byp2_idx,
    output logic       byp1_done,
    output logic       byp2_done,
    output word_t      byp1_data,
    output word_t      byp2_data,

    output logic       commit_valid,
    output commit_t    commit,
    output rob_idx_t   commit_idx
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    if (ROB_DEPTH != 2 ** $bits(rob_idx_t)) begin : g_depth_check
        $error("ROB_DEPTH must be 2 ** $bits(rob_idx_t)");
    end

    logic [ROB_DEPTH-1:0] busy_q;
    logic [ROB_DEPTH-1:0] done_q;
    reg_idx_t             rd_q   [ROB_DEPTH];
    logic                 wr_q   [ROB_DEPTH];
    word_t                data_q [ROB_DEPTH];

    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [CNT_W-1:0]     count_q;

    assign alloc_idx = tail_q;
    assign full      = (count_q == CNT_W'(ROB_DEPTH));

    assign byp1_done = busy_q[byp1_idx] && done_q[byp1_idx];
    assign byp2_done = busy_q[byp2_idx] && done_q[byp2_idx];
    assign byp1_data = data_q[byp1_idx];
    assign byp2_data = data_q[byp2_idx];

    // Retire the head as soon as it is done.
    assign commit_valid = busy_q[head_q] && done_q[head_q] && !flush;
    assign commit_idx   = head_q;
    assign commit       = '{rd: rd_q[head_q], data: data_q[head_q], writes_rd: wr_q[head_q]};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (commit_valid) begin
                busy_q[head_q] <= 1'b0;
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;  // Wraps with the index width.
            end
            if (alloc) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (wb_valid) begin
                done_q[wb.idx] <= 1'b1;
            end
            case ({alloc, commit_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload, qualified by busy/done.
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_q] <= alloc_instr.rd;
            wr_q[tail_q] <= renames_rd(alloc_instr);
        end
        if (wb_valid) begin
            data_q[wb.idx] <= wb.data;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        alloc |-> !full)
        else $error("alloc while ROB full");

    // Execution units may only complete live, unfinished entries.
    assert property (@(posedge clk) disable iff (rst || flush)
        wb_valid |-> busy_q[wb.idx] && !done_q[wb.idx])
        else $error("writeback to idle or finished entry %0d", wb.idx);

endmodule

/* rtl/dispatch_stage.sv */
`timescale 1ns/100ps

module dispatch_stage
    import rename_pkg::*;
#(
    parameter int ISSUE_CREDITS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  logic        in_valid,
    input  dec_instr_t  in_instr,
    output logic        in_ready,

    input  logic        rob_full,
    output logic        alloc,
    input  rob_idx_t    alloc_idx,

    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  rob_tag_t    rs1_tag,
    input  rob_tag_t    rs2_tag,
    input  logic        byp1_done,
    input  logic        byp2_done,
    input  word_t       byp1_data,
    input  word_t       byp2_data,

    output logic        rename_en,

    input  logic        credit_return,
    output logic        disp_valid,
    output disp_instr_t disp_instr
);

    localparam int CW = $clog2(ISSUE_CREDITS + 1);

    logic [CW-1:0] credits_q;
    logic          accept;
    operand_t      src1;
    operand_t      src2;

    function automatic operand_t make_operand(rob_tag_t tag, word_t rf_data,
                                              logic byp_done, word_t byp_data);
        operand_t opnd;
        opnd.tag = tag;
        if (!tag.pending) begin
            opnd.ready = 1'b1;
            opnd.data  = rf_data;
        end else if (byp_done) begin
            opnd.ready = 1'b1;  // Producer finished, not yet committed.
            opnd.data  = byp_data;
        end else begin
            opnd.ready = 1'b0;
            opnd.data  = '0;
        end
        return opnd;
    endfunction

    assign in_ready  = (credits_q != '0) && !rob_full && !flush;
    assign accept    = in_valid && in_ready;
    assign alloc     = accept;
    assign rename_en = accept && renames_rd(in_instr);

    assign src1 = make_operand(rs1_tag, rs1_data, byp1_done, byp1_data);
    assign src2 = make_operand(rs2_tag, rs2_data, byp2_done, byp2_data);

    // A credit is spent at the edge that raises disp_valid.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credits_q <= CW'(ISSUE_CREDITS);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp_instr <= '{instr: in_instr, src1: src1, src2: src2, rob_idx: alloc_idx};
        end
    end

    // The issue queue never returns more than it was given.
    assert property (@(posedge clk) disable iff (rst || flush)
        credit_return && !accept |-> credits_q < CW'(ISSUE_CREDITS))
        else $error("issue credits above %0d", ISSUE_CREDITS);

endmodule

/* rtl/rename_top.sv */
`timescale 1ns/100ps

module rename_top
    import rename_pkg::*;
#(
    parameter int ROB_DEPTH     = 8,
    parameter int ISSUE_CREDITS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  logic        in_valid,
    input  dec_instr_t  in_instr,
    output logic        in_ready,

    input  logic        credit_return,
    output logic        disp_valid,
    output disp_instr_t disp_instr,

    input  logic        wb_valid,
    input  wb_t         wb,

    output logic        commit_valid,
    output commit_t     commit
);

    logic     alloc;
    rob_idx_t alloc_idx;
    logic     rob_full;
    logic     rename_en;
    rob_idx_t commit_idx;

    word_t    rs1_data;
    word_t    rs2_data;
    rob_tag_t rs1_tag;
    rob_tag_t rs2_tag;
    logic     byp1_done;
    logic     byp2_done;
    word_t    byp1_data;
    word_t    byp2_data;

    rename_regfile #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_regfile (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .rs1_idx      (in_instr.rs1),
        .rs2_idx      (in_instr.rs2),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag),
        .rename_en    (rename_en),
        .rename_rd    (in_instr.rd),
        .rename_idx   (alloc_idx),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_idx   (commit_idx)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc        (alloc),
        .alloc_instr  (in_instr),
        .alloc_idx    (alloc_idx),
        .full         (rob_full),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .byp1_idx     (rs1_tag.idx),  // Pending producers of the two sources.
        .byp2_idx     (rs2_tag.idx),
        .byp1_done    (byp1_done),
        .byp2_done    (byp2_done),
        .byp1_data    (byp1_data),
        .byp2_data    (byp2_data),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_idx   (commit_idx)
    );

    dispatch_stage #(
        .ISSUE_CREDITS (ISSUE_CREDITS)
    ) u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_ready      (in_ready),
        .rob_full      (rob_full),
        .alloc         (alloc),
        .alloc_idx     (alloc_idx),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rs1_tag       (rs1_tag),
        .rs2_tag       (rs2_tag),
        .byp1_done     (byp1_done),
        .byp2_done     (byp2_done),
        .byp1_data     (byp1_data),
        .byp2_data     (byp2_data),
        .rename_en     (rename_en),
        .credit_return (credit_return),
        .disp_valid    (disp_valid),
        .disp_instr    (disp_instr)
    );

endmodule

/* tb/rename_tests.svh */
// Model of register values and tags, plus the ROB entries in flight.
word_t    model_val  [num_regs];
logic     model_pend [num_regs];
rob_idx_t model_tag  [num_regs];
logic     rob_busy   [ROB_DEPTH];
logic     rob_done   [ROB_DEPTH];
word_t    rob_data   [ROB_DEPTH];
reg_idx_t rob_rd     [ROB_DEPTH];
logic     rob_wr     [ROB_DEPTH];
rob_idx_t head_m;
rob_idx_t tail_m;  // Next allocation index.
int       count_m;
logic     auto_credit;
integer   seed = 32'hd201_556e;

task automatic reset_model(input logic keep_values);
    for (int i = 0; i < num_regs; i++) begin
        if (!keep_values) begin
            model_val[i] = '0;
        end
        model_pend[i] = 1'b0;
        model_tag[i]  = '0;
    end
    for (int i = 0; i < ROB_DEPTH; i++) begin
        rob_busy[i] = 1'b0;
        rob_done[i] = 1'b0;
    end
    head_m  = '0;
    tail_m  = '0;
    count_m = 0;
endtask

task automatic retire_head();
    if (rob_wr[head_m]) begin
        model_val[rob_rd[head_m]] = rob_data[head_m];
        if (model_pend[rob_rd[head_m]] && model_tag[rob_rd[head_m]] == head_m) begin
            model_pend[rob_rd[head_m]] = 1'b0;  // A younger writer keeps its tag.
        end
    end
    rob_busy[head_m] = 1'b0;
    rob_done[head_m] = 1'b0;
    head_m  = rob_idx_t'((head_m + 1) % ROB_DEPTH);
    count_m = count_m - 1;
endtask

function automatic operand_t expect_operand(reg_idx_t r);
    operand_t opnd;
    opnd = '0;
    if (!model_pend[r]) begin
        opnd.ready = 1'b1;
        opnd.data  = model_val[r];
    end else begin
        opnd.tag = '{pending: 1'b1, idx: model_tag[r]};
        if (rob_done[model_tag[r]]) begin
            opnd.ready = 1'b1;  // Done in the ROB.
            opnd.data  = rob_data[model_tag[r]];
        end
    end
    return opnd;
endfunction

task automatic clear_inputs();
    in_valid      = 1'b0;
    credit_return = 1'b0;
    wb_valid      = 1'b0;
    flush         = 1'b0;
endtask

task automatic issue_instr(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs1,
                           input reg_idx_t rs2, output rob_idx_t idx);
    dec_instr_t instr;
    operand_t   exp1;
    operand_t   exp2;
    logic       writes;
    @(negedge clk);
    clear_inputs();
    instr    = '{op: op, rd: rd, rs1: rs1, rs2: rs2, pc: $random(seed), imm: $random(seed)};
    in_valid = 1'b1;
    in_instr = instr;
    exp1     = expect_operand(rs1);
    exp2     = expect_operand(rs2);
    writes   = (op == op_alu || op == op_load) && rd != '0;
    #1;
    check_equal("in_ready", in_ready, 1'b1);
    @(negedge clk);
    in_valid      = 1'b0;
    credit_return = auto_credit;  // Issue queue frees its slot at once.
    check_equal("disp_valid", disp_valid, 1'b1);
    check_equal("disp_instr.instr", disp_instr.instr, instr);
    check_equal("disp_instr.src1", disp_instr.src1, exp1);
    check_equal("disp_instr.src2", disp_instr.src2, exp2);
    check_equal("disp_instr.rob_idx", disp_instr.rob_idx, tail_m);
    idx           = tail_m;
    rob_busy[idx] = 1'b1;
    rob_rd[idx]   = rd;
    rob_wr[idx]   = writes;
    tail_m        = rob_idx_t'((tail_m + 1) % ROB_DEPTH);
    count_m       = count_m + 1;
    if (writes) begin
        model_pend[rd] = 1'b1;
        model_tag[rd]  = idx;
    end
endtask

task automatic write_back(input rob_idx_t idx);
    word_t data;
    data = $random(seed);
    @(negedge clk);
    clear_inputs();
    wb_valid = 1'b1;
    wb       = '{idx: idx, data: data};
    @(negedge clk);
    wb_valid      = 1'b0;
    rob_done[idx] = 1'b1;
    rob_data[idx] = data;
endtask

task automatic expect_blocked();
    @(negedge clk);
    clear_inputs();
    in_valid = 1'b1;
    #1;
    check_equal("in_ready", in_ready, 1'b0);
    @(negedge clk);
    in_valid = 1'b0;
    check_equal("disp_valid", disp_valid, 1'b0);
endtask

task automatic return_credit();
    @(negedge clk);
    clear_inputs();
    credit_return = 1'b1;
endtask

task automatic flush_pipeline();
    @(negedge clk);
    clear_inputs();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    reset_model(1'b1);
    #1;
    check_equal("in_ready", in_ready, 1'b1);
endtask

task automatic drain_rob();
    int n;
    n = 0;
    while (count_m != 0 && n < 20) begin
        @(negedge clk);
        clear_inputs();
        n++;
    end
    if (count_m != 0) begin
        abort_run("The ROB entries did not all commit in time.");
    end
endtask

task automatic test_reset_credits();
    rob_idx_t idx;
    check_equal("in_ready", in_ready, 1'b1);
    check_equal("disp_valid", disp_valid, 1'b0);
    check_equal("commit_valid", commit_valid, 1'b0);
    for (int i = 0; i < ISSUE_CREDITS; i++) begin
        issue_instr(op_store, 5'd0, 5'd1, 5'd2, idx);
    end
    expect_blocked();
    return_credit();
    issue_instr(op_store, 5'd0, 5'd1, 5'd2, idx);
    expect_blocked();
    flush_pipeline();
    auto_credit = 1'b1;
endtask

task automatic test_dependence();
    rob_idx_t older;
    rob_idx_t prod;
    rob_idx_t rd1;
    rob_idx_t rd2;
    rob_idx_t rd3;
    issue_instr(op_alu, 5'd6, 5'd0, 5'd0, older);
    issue_instr(op_alu, 5'd5, 5'd0, 5'd0, prod);
    issue_instr(op_alu, 5'd10, 5'd5, 5'd6, rd1);
    check_equal("src1.ready", disp_instr.src1.ready, 1'b0);
    check_equal("src1.tag.idx", disp_instr.src1.tag.idx, prod);
    write_back(prod);
    issue_instr(op_alu, 5'd11, 5'd5, 5'd0, rd2);  // Older entry still blocks commit.
    check_equal("src1.ready", disp_instr.src1.ready, 1'b1);
    write_back(older);
    write_back(rd1);
    write_back(rd2);
    drain_rob();
    issue_instr(op_load, 5'd12, 5'd5, 5'd11, rd3);
    check_equal("src1.tag.pending", disp_instr.src1.tag.pending, 1'b0);
    write_back(rd3);
    drain_rob();
endtask

task automatic test_in_order_commit();
    rob_idx_t idx [4];
    for (int i = 0; i < 4; i++) begin
        issue_instr(op_alu, reg_idx_t'(20 + i), 5'd0, 5'd0, idx[i]);
    end
    for (int i = 3; i >= 0; i--) begin
        write_back(idx[i]);
    end
    drain_rob();
endtask

task automatic test_non_renaming();
    rob_idx_t idx [5];
    issue_instr(op_store, 5'd7, 5'd1, 5'd2, idx[0]);
    issue_instr(op_branch, 5'd8, 5'd1, 5'd2, idx[1]);
    issue_instr(op_alu, 5'd0, 5'd1, 5'd2, idx[2]);
    issue_instr(op_alu, 5'd9, 5'd7, 5'd8, idx[3]);
    check_equal("src1.tag.pending", disp_instr.src1.tag.pending, 1'b0);
    check_equal("src2.tag.pending", disp_instr.src2.tag.pending, 1'b0);
    issue_instr(op_alu, 5'd14, 5'd0, 5'd0, idx[4]);
    check_equal("src1", disp_instr.src1, operand_t'{ready: 1'b1, data: '0, tag: '0});
    for (int i = 0; i < 5; i++) begin
        write_back(idx[i]);
    end
    drain_rob();
endtask

task automatic test_stale_commit();
    rob_idx_t w1;
    rob_idx_t w2;
    rob_idx_t rdr;
    issue_instr(op_alu, 5'd5, 5'd0, 5'd0, w1);
    issue_instr(op_load, 5'd5, 5'd0, 5'd0, w2);
    write_back(w1);
    issue_instr(op_alu, 5'd15, 5'd5, 5'd0, rdr);  // First writer has committed.
    check_equal("src1.ready", disp_instr.src1.ready, 1'b0);
    check_equal("src1.tag.idx", disp_instr.src1.tag.idx, w2);
    write_back(w2);
    write_back(rdr);
    drain_rob();
endtask

task automatic test_flush();
    rob_idx_t w;
    rob_idx_t rdr;
    issue_instr(op_alu, 5'd9, 5'd0, 5'd0, w);
    issue_instr(op_alu, 5'd12, 5'd9, 5'd0, rdr);
    write_back(rdr);  // Done but behind an unfinished head.
    flush_pipeline();
    issue_instr(op_alu, 5'd16, 5'd9, 5'd12, rdr);
    check_equal("disp_instr.rob_idx", disp_instr.rob_idx, 3'd0);
    check_equal("src1.ready", disp_instr.src1.ready, 1'b1);
    write_back(rdr);
    drain_rob();
endtask

/* tb/tb_rename_top.sv */
`timescale 1ns/100ps

module tb_rename_top;
    import rename_pkg::*;

    localparam int ROB_DEPTH     = 8;
    localparam int ISSUE_CREDITS = 4;
    localparam int NUM_TESTS     = 6;
    localparam int TEST_CYCLES   = 100;  // Upper bound for one test.

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic        in_valid;
    dec_instr_t  in_instr;
    logic        in_ready;
    logic        credit_return;
    logic        disp_valid;
    disp_instr_t disp_instr;
    logic        wb_valid;
    wb_t         wb;
    logic        commit_valid;
    commit_t     commit;
    logic        exp_commit;

    always #4 clk = ~clk;

    rename_top #(
        .ROB_DEPTH     (ROB_DEPTH),
        .ISSUE_CREDITS (ISSUE_CREDITS)
    ) u_rename_top (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .disp_valid    (disp_valid),
        .disp_instr    (disp_instr),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .commit_valid  (commit_valid),
        .commit        (commit)
    );

    `include "rename_tests.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // Each edge, commit_valid must match the head entry of the model.
    always @(posedge clk) begin
        if (!rst) begin
            exp_commit = rob_busy[head_m] && rob_done[head_m] && !flush;
            check_equal("commit_valid", commit_valid, exp_commit);
            if (exp_commit) begin
                check_equal("commit.rd", commit.rd, rob_rd[head_m]);
                check_equal("commit.data", commit.data, rob_data[head_m]);
                check_equal("commit.writes_rd", commit.writes_rd, rob_wr[head_m]);
                retire_head();
            end
        end
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 8);
        abort_run("Timeout: the test sequence did not finish in time.");
    end

    initial begin
        rst           = 1'b1;
        in_instr      = '0;
        wb            = '0;
        auto_credit   = 1'b0;
        clear_inputs();
        reset_model(1'b0);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset_credits();
        test_dependence();
        test_in_order_commit();
        test_non_renaming();
        test_stale_commit();
        test_flush();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* rename_core.f */
+incdir+tb
common/rename_pkg.sv
regfile/rename_regfile.sv
rob/reorder_buffer.sv
rtl/dispatch_stage.sv
rtl/rename_top.sv
tb/tb_rename_top.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - common/rename_pkg.sv
  - regfile/rename_regfile.sv
  - rob/reorder_buffer.sv
  - rtl/dispatch_stage.sv
  - rtl/rename_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_rename_top.sv
